//--- Bender.yml
package:
  name: trigger_top

sources:
  - trig_types_pkg.sv
  - trig_regmap_pkg.sv
  - trig_chan_if.sv
  - trig_ctrl_regs.sv
  - l4_channel.sv
  - trig_handler.sv
  - trigger_top.sv
  - target: test
    files:
      - tb_trigger_top.sv

//--- flist.f
trig_types_pkg.sv
trig_regmap_pkg.sv
trig_chan_if.sv
trig_ctrl_regs.sv
l4_channel.sv
trig_handler.sv
trigger_top.sv
tb_trigger_top.sv

//--- l4_channel.sv
`timescale 1ns/10ps

module l4_channel (
	input  logic      fclk_i,
	input  logic      rst_i,
	input  logic      flag_i,
	trig_chan_if.chan ch
);
	import trig_types_pkg::*;

	// Stretch state.
	chan_state_e state_q;
	// Cycles left in the stretch after the current one.
	blocks_t left_q;
	// Reload value, max(blocks,1) minus one.
	blocks_t stretch_len;
	// First cycle of a stretch.
	logic new_q;
	// Flag taken this edge.
	logic accept;
	// Accepted-trigger counter.
	count_t count_q;
	// Undelayed trigger level.
	logic act_now;
	// Alignment shift lines, stage 1 is one cycle late.
	logic [DELAY_STAGES:1] act_sr;
	logic [DELAY_STAGES:1] new_sr;
	// Tap vectors, index is the delay in cycles.
	logic [DELAY_STAGES:0] act_tap;
	logic [DELAY_STAGES:0] new_tap;

	//////////////////////////////////////////////////
	// Accept and stretch
	//////////////////////////////////////////////////

	// Only an idle channel looks at the flag.
	assign accept = flag_i && !ch.mask && (state_q == CH_IDLE);

	// Zero blocks acts as a single block.
	assign stretch_len = (ch.blocks == '0) ? blocks_t'(0) : ch.blocks - blocks_t'(1);

	always_ff @(posedge fclk_i) begin
		if (rst_i) begin
			state_q <= CH_IDLE;
			new_q <= 1'b0;
		end else begin
			case (state_q)
				CH_IDLE: begin
					new_q <= accept;
					if (accept) begin
						state_q <= CH_STRETCH;
					end
				end
				CH_STRETCH: begin
					// Flags here are ignored.
					new_q <= 1'b0;
					if (left_q == '0) begin
						state_q <= CH_IDLE;
					end
				end
				default: begin
					state_q <= CH_IDLE;
					new_q <= 1'b0;
				end
			endcase
		end
	end

	// Down-counter, loaded on accept and only read while stretching.
	always_ff @(posedge fclk_i) begin
		if (accept) begin
			left_q <= stretch_len;
		end else if (state_q == CH_STRETCH) begin
			left_q <= left_q - blocks_t'(1);
		end
	end

	// The level is simply the stretch state.
	assign act_now = (state_q == CH_STRETCH);

	//////////////////////////////////////////////////
	// Accept counter
	//////////////////////////////////////////////////

	always_ff @(posedge fclk_i) begin
		if (rst_i) begin
			count_q <= '0;
		end else if (accept) begin
			// Wraps silently.
			count_q <= count_q + count_t'(1);
		end
	end

	assign ch.accept_count = count_q;

	//////////////////////////////////////////////////
	// Alignment delay
	//////////////////////////////////////////////////

	// Lines start empty so nothing stale leaks out after reset.
	always_ff @(posedge fclk_i) begin
		if (rst_i) begin
			act_sr <= '0;
			new_sr <= '0;
		end else begin
			act_sr <= {act_sr[DELAY_STAGES-1:1], act_now};
			new_sr <= {new_sr[DELAY_STAGES-1:1], new_q};
		end
	end

	// Tap 0 is the undelayed signal.
	assign act_tap = {act_sr, act_now};
	assign new_tap = {new_sr, new_q};

	// Select at the programmed delay.
	assign ch.active = act_tap[ch.delay];
	assign ch.new_pulse = new_tap[ch.delay];

endmodule

//--- tb_trigger_top.sv
`timescale 1ns/10ps

module tb_trigger_top;
	import trig_types_pkg::*;
	import trig_regmap_pkg::*;

	localparam int N_CH = NUM_CH;
	// Directed phases take about 350 cycles, random traffic the rest.
	localparam int RUN_CYCLES = 3000;
	localparam int MAX_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;

	logic fclk_i;
	logic rst_i;
	logic [N_CH-1:0] l4_flag_i;
	logic cfg_we_i;
	reg_addr_t cfg_addr_i;
	reg_data_t cfg_wdata_i;
	reg_data_t cfg_rdata_o;
	logic readout_ready_i;
	logic disable_i;
	logic disable_ce_i;
	logic trig_o;
	logic [N_CH-1:0] trig_l4_o;
	logic [N_CH-1:0] trig_l4_new_o;
	delay_t trig_delay_o;

	integer seed;
	int cyc;

	// Reference model state.
	logic [N_CH-1:0] m_mask;
	logic m_t1;
	logic m_dis;
	blocks_t m_blocks [N_CH];
	delay_t m_delay [N_CH];
	count_t m_count [N_CH];
	logic m_state [N_CH];
	blocks_t m_left [N_CH];
	logic m_new [N_CH];
	// Index is the age in cycles, 0 is the undelayed value.
	logic m_act_h [N_CH][DELAY_STAGES+1];
	logic m_new_h [N_CH][DELAY_STAGES+1];
	// Model outputs.
	logic m_trig;
	logic [N_CH-1:0] m_l4;
	logic [N_CH-1:0] m_l4_new;
	delay_t m_dly;
	reg_data_t m_rdata;

	// Output statistics for the directed phases.
	int n_trig;
	int n_l4 [N_CH];
	delay_t trig_dly_q [$];

	trigger_top #(
		.N_CH(N_CH)
	) dut0 (
		.fclk_i          (fclk_i),
		.rst_i           (rst_i),
		.l4_flag_i       (l4_flag_i),
		.cfg_we_i        (cfg_we_i),
		.cfg_addr_i      (cfg_addr_i),
		.cfg_wdata_i     (cfg_wdata_i),
		.cfg_rdata_o     (cfg_rdata_o),
		.readout_ready_i (readout_ready_i),
		.disable_i       (disable_i),
		.disable_ce_i    (disable_ce_i),
		.trig_o          (trig_o),
		.trig_l4_o       (trig_l4_o),
		.trig_l4_new_o   (trig_l4_new_o),
		.trig_delay_o    (trig_delay_o)
	);

	// 20 ns period.
	initial fclk_i = 1'b0;
	always #10 fclk_i = ~fclk_i;

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "compare error at cycle %0d", cyc);
		end
	endtask

	task automatic check_vec(input string name, input logic [N_CH-1:0] got,
			input logic [N_CH-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "compare error at cycle %0d", cyc);
		end
	endtask

	task automatic check_delay(input string name, input delay_t got, input delay_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "compare error at cycle %0d", cyc);
		end
	endtask

	task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "compare error at cycle %0d", cyc);
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run aborted at cycle %0d", cyc);
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	task automatic reset_model();
		m_mask = '0;
		m_t1 = 1'b0;
		m_dis = 1'b0;
		m_trig = 1'b0;
		m_l4 = '0;
		m_l4_new = '0;
		m_dly = '0;
		m_rdata = '0;
		for (int k = 0; k < N_CH; k++) begin
			m_blocks[k] = 8'd1;
			m_delay[k] = '0;
			m_count[k] = '0;
			m_state[k] = 1'b0;
			m_left[k] = '0;
			m_new[k] = 1'b0;
			for (int d = 0; d <= DELAY_STAGES; d++) begin
				m_act_h[k][d] = 1'b0;
				m_new_h[k][d] = 1'b0;
			end
		end
	endtask

	// One clock edge, every stage reads the values from before the edge.
	task automatic step_model();
		logic gate;
		logic found;
		int a;
		gate = !m_t1 && readout_ready_i && !m_dis;
		found = 1'b0;
		m_dly = '0;
		// Handler registers the aligned taps.
		for (int k = 0; k < N_CH; k++) begin
			m_l4[k] = m_act_h[k][m_delay[k]];
			m_l4_new[k] = m_new_h[k][m_delay[k]];
			if (m_l4_new[k] && !found) begin
				found = 1'b1;
				m_dly = m_delay[k];
			end
		end
		m_trig = found && gate;
		// Registered readback.
		a = cfg_addr_i;
		m_rdata = '0;
		if (a == ADDR_CTRL) begin
			m_rdata[N_CH-1:0] = m_mask;
			m_rdata[15] = m_t1;
		end else if (a >= ADDR_CHAN_BASE && a < ADDR_CHAN_BASE + N_CH) begin
			m_rdata = {4'h0, m_delay[a-ADDR_CHAN_BASE], m_blocks[a-ADDR_CHAN_BASE]};
		end else if (a >= ADDR_COUNT_BASE && a < ADDR_COUNT_BASE + N_CH) begin
			m_rdata = m_count[a-ADDR_COUNT_BASE];
		end
		// Channels.
		for (int k = 0; k < N_CH; k++) begin
			for (int d = DELAY_STAGES; d >= 1; d--) begin
				m_act_h[k][d] = m_act_h[k][d-1];
				m_new_h[k][d] = m_new_h[k][d-1];
			end
			if (!m_state[k]) begin
				m_new[k] = l4_flag_i[k] && !m_mask[k];
				if (m_new[k]) begin
					m_state[k] = 1'b1;
					// Active cycles still to come, at least one.
					m_left[k] = (m_blocks[k] == 0) ? 8'd1 : m_blocks[k];
					m_count[k] = m_count[k] + 16'd1;
				end
			end else begin
				m_new[k] = 1'b0;
				m_left[k] = m_left[k] - 8'd1;
				if (m_left[k] == 0) begin
					m_state[k] = 1'b0;
				end
			end
			m_act_h[k][0] = m_state[k];
			m_new_h[k][0] = m_new[k];
		end
		if (disable_ce_i) begin
			m_dis = disable_i;
		end
		// Writes land last, so channels see them one edge later.
		if (cfg_we_i) begin
			if (cfg_addr_i == ADDR_CTRL) begin
				m_mask = cfg_wdata_i[N_CH-1:0];
				m_t1 = cfg_wdata_i[15];
			end
			for (int k = 0; k < N_CH; k++) begin
				if (cfg_addr_i == ADDR_CHAN_BASE + k) begin
					m_blocks[k] = cfg_wdata_i[7:0];
					m_delay[k] = cfg_wdata_i[11:8];
				end
			end
		end
	endtask

	always @(posedge fclk_i) begin
		if (rst_i) begin
			reset_model();
		end else begin
			step_model();
		end
	end

	// Outputs are compared mid-cycle, where they are settled.
	always @(negedge fclk_i) begin
		if (!rst_i) begin
			check_bit("trig_o", trig_o, m_trig);
			check_vec("trig_l4_o", trig_l4_o, m_l4);
			check_vec("trig_l4_new_o", trig_l4_new_o, m_l4_new);
			check_delay("trig_delay_o", trig_delay_o, m_dly);
			check_data("cfg_rdata_o", cfg_rdata_o, m_rdata);
			if (trig_o) begin
				n_trig++;
				trig_dly_q.push_back(trig_delay_o);
			end
			for (int k = 0; k < N_CH; k++) begin
				if (trig_l4_o[k]) begin
					n_l4[k]++;
				end
			end
		end
	end

	always @(posedge fclk_i) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge fclk_i);
	endtask

	task automatic write_reg(input reg_addr_t a, input reg_data_t d);
		@(posedge fclk_i);
		cfg_we_i <= 1'b1;
		cfg_addr_i <= a;
		cfg_wdata_i <= d;
		@(posedge fclk_i);
		cfg_we_i <= 1'b0;
	endtask

	// Address is sampled one edge later, data shows after that edge.
	task automatic read_reg(input reg_addr_t a, input reg_data_t exp);
		@(posedge fclk_i);
		cfg_addr_i <= a;
		@(posedge fclk_i);
		@(negedge fclk_i);
		check_data("cfg_rdata_o", cfg_rdata_o, exp);
	endtask

	task automatic pulse_flags(input logic [N_CH-1:0] f);
		@(posedge fclk_i);
		l4_flag_i <= f;
		@(posedge fclk_i);
		l4_flag_i <= '0;
	endtask

	task automatic clear_stats();
		n_trig = 0;
		for (int k = 0; k < N_CH; k++) begin
			n_l4[k] = 0;
		end
		trig_dly_q.delete();
	endtask

	// One flag on one channel, then count the global pulses.
	task automatic fire_gated(input int ch, input int exp_trig);
		clear_stats();
		pulse_flags(N_CH'(1) << ch);
		wait_cycles(30);
		@(negedge fclk_i);
		check_data("trig_o pulses", reg_data_t'(n_trig), reg_data_t'(exp_trig));
		if (n_l4[ch] == 0) begin
			abort_run("trig_l4_o never rose for the fired channel");
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : stim
		logic [31:0] r;
		logic [N_CH-1:0] f;
		seed = 11;
		cyc = 0;
		rst_i = 1'b1;
		l4_flag_i = '0;
		cfg_we_i = 1'b0;
		cfg_addr_i = '0;
		cfg_wdata_i = '0;
		readout_ready_i = 1'b1;
		disable_i = 1'b0;
		disable_ce_i = 1'b0;
		clear_stats();
		wait_cycles(5);
		rst_i <= 1'b0;

		// Phase 1, reset values.
		@(negedge fclk_i);
		check_bit("trig_o", trig_o, 1'b0);
		check_vec("trig_l4_o", trig_l4_o, '0);
		check_vec("trig_l4_new_o", trig_l4_new_o, '0);
		check_delay("trig_delay_o", trig_delay_o, 4'd0);
		read_reg(4'd0, 16'h0000);
		for (int k = 1; k <= 3; k++) begin
			read_reg(reg_addr_t'(k), 16'h0001);
		end

		// Phase 2, single trigger with blocks 5 and delay 3.
		write_reg(4'd1, 16'h0305);
		clear_stats();
		pulse_flags(3'b001);
		wait_cycles(30);
		@(negedge fclk_i);
		check_data("trig_o pulses", reg_data_t'(n_trig), 16'd1);
		check_data("trig_l4_o[0] cycles", reg_data_t'(n_l4[0]), 16'd5);
		check_delay("trig_delay_o at trigger", trig_dly_q[0], 4'd3);

		// Phase 3, masked channel and a flag during the stretch.
		write_reg(4'd0, 16'h0002);
		write_reg(4'd1, 16'h030A);
		clear_stats();
		pulse_flags(3'b011);
		wait_cycles(3);
		pulse_flags(3'b001);
		wait_cycles(30);
		@(negedge fclk_i);
		check_data("trig_o pulses", reg_data_t'(n_trig), 16'd1);
		check_data("trig_l4_o[0] cycles", reg_data_t'(n_l4[0]), 16'd10);
		check_data("trig_l4_o[1] cycles", reg_data_t'(n_l4[1]), 16'd0);
		read_reg(4'd8, 16'd2);
		read_reg(4'd9, 16'd0);
		read_reg(4'd10, 16'd0);

		// Phase 4, each gate alone holds back the global trigger.
		write_reg(4'd0, 16'h8000);
		fire_gated(2, 0);
		write_reg(4'd0, 16'h0000);
		@(posedge fclk_i);
		readout_ready_i <= 1'b0;
		fire_gated(2, 0);
		@(posedge fclk_i);
		readout_ready_i <= 1'b1;
		// No strobe, so the latch keeps its old value.
		disable_i <= 1'b1;
		fire_gated(2, 1);
		@(posedge fclk_i);
		disable_ce_i <= 1'b1;
		@(posedge fclk_i);
		disable_ce_i <= 1'b0;
		fire_gated(2, 0);
		@(posedge fclk_i);
		disable_i <= 1'b0;
		disable_ce_i <= 1'b1;
		@(posedge fclk_i);
		disable_ce_i <= 1'b0;
		fire_gated(2, 1);

		// Phase 5, all channels at once with different delays.
		write_reg(4'd1, 16'h0702);
		write_reg(4'd2, 16'h0203);
		write_reg(4'd3, 16'h0C01);
		clear_stats();
		pulse_flags(3'b111);
		wait_cycles(30);
		@(negedge fclk_i);
		check_data("trig_o pulses", reg_data_t'(n_trig), 16'd3);
		check_delay("first trig_delay_o", trig_dly_q[0], 4'd2);
		check_delay("second trig_delay_o", trig_dly_q[1], 4'd7);
		check_delay("third trig_delay_o", trig_dly_q[2], 4'd12);
		// Two accepts two cycles apart meet after their delays.
		write_reg(4'd1, 16'h0301);
		write_reg(4'd2, 16'h0501);
		clear_stats();
		pulse_flags(3'b010);
		pulse_flags(3'b001);
		wait_cycles(30);
		@(negedge fclk_i);
		check_data("trig_o pulses", reg_data_t'(n_trig), 16'd1);
		check_delay("trig_delay_o at trigger", trig_dly_q[0], 4'd3);

		// Phase 6, random traffic against the model.
		repeat (2400) begin
			@(posedge fclk_i);
			r = $random(seed);
			for (int k = 0; k < N_CH; k++) begin
				f[k] = (($random(seed) & 15) == 0);
			end
			l4_flag_i <= f;
			cfg_we_i <= (r[3:0] == 4'd0);
			cfg_addr_i <= r[7:4];
			cfg_wdata_i <= reg_data_t'($random(seed));
			readout_ready_i <= (r[10:8] != 3'd0);
			disable_i <= r[11];
			disable_ce_i <= (r[15:12] == 4'd0);
		end
		@(posedge fclk_i);
		l4_flag_i <= '0;
		cfg_we_i <= 1'b0;
		wait_cycles(40);
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- trig_chan_if.sv
`timescale 1ns/10ps

interface trig_chan_if;
	import trig_types_pkg::*;

	// Programmed by the register block.
	// Mask high drops the source flag.
	logic mask;
	// Stretch length of an accepted trigger.
	blocks_t blocks;
	// Alignment delay, also reported by the handler.
	delay_t delay;

	// Aligned trigger level from the channel.
	logic active;
	// Aligned first-cycle marker of a trigger.
	logic new_pulse;
	// Running count of accepted triggers.
	count_t accept_count;

	// Register block side.
	modport cfg (
		output mask, blocks, delay,
		input  accept_count
	);

	// Source channel side.
	modport chan (
		input  mask, blocks, delay,
		output active, new_pulse, accept_count
	);

	// Trigger handler side.
	modport sink (
		input active, new_pulse, delay
	);

endinterface

//--- trig_ctrl_regs.sv
`timescale 1ns/10ps

module trig_ctrl_regs #(
	parameter int N_CH = trig_types_pkg::NUM_CH
) (
	input  logic                        fclk_i,
	input  logic                        rst_i,
	input  logic                        cfg_we_i,
	input  trig_regmap_pkg::reg_addr_t  cfg_addr_i,
	input  trig_regmap_pkg::reg_data_t  cfg_wdata_i,
	output trig_regmap_pkg::reg_data_t  cfg_rdata_o,
	output logic                        t1_mask_o,
	trig_chan_if.cfg                    chans [N_CH]
);
	import trig_types_pkg::*;
	import trig_regmap_pkg::*;

	// Channels come out of reset with a one-cycle stretch.
	localparam blocks_t BLOCKS_RESET = blocks_t'(1);

	// Per-channel masks, 1 means masked.
	logic [N_CH-1:0] mask_q;
	// Global trigger mask.
	logic t1_mask_q;
	// Per-channel stretch and alignment settings.
	blocks_t blocks_q [N_CH];
	delay_t delay_q [N_CH];
	// Counters gathered from the channels.
	count_t count_w [N_CH];
	// Readback mux output and its register.
	reg_data_t rd_word;
	reg_data_t rdata_q;

	//////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////

	// Writes land on the edge of the strobe.
	// Channels see the new values from the next edge.
	always_ff @(posedge fclk_i) begin
		if (rst_i) begin
			mask_q <= '0;
			t1_mask_q <= 1'b0;
			for (int k = 0; k < N_CH; k++) begin
				blocks_q[k] <= BLOCKS_RESET;
				delay_q[k] <= '0;
			end
		end else if (cfg_we_i) begin
			// Control word.
			if (cfg_addr_i == ADDR_CTRL) begin
				mask_q <= cfg_wdata_i[N_CH-1:0];
				t1_mask_q <= cfg_wdata_i[CTRL_T1_MASK_BIT];
			end
			// Channel words, one per source.
			for (int k = 0; k < N_CH; k++) begin
				if (cfg_addr_i == ADDR_CHAN_BASE + reg_addr_t'(k)) begin
					blocks_q[k] <= cfg_wdata_i[CHAN_BLOCKS_LSB +: $bits(blocks_t)];
					delay_q[k] <= cfg_wdata_i[CHAN_DELAY_LSB +: $bits(delay_t)];
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Channel connections
	//////////////////////////////////////////////////

	for (genvar g = 0; g < N_CH; g++) begin : g_chan
		assign chans[g].mask = mask_q[g];
		assign chans[g].blocks = blocks_q[g];
		assign chans[g].delay = delay_q[g];
		// Counter comes back for readout.
		assign count_w[g] = chans[g].accept_count;
	end

	assign t1_mask_o = t1_mask_q;

	//////////////////////////////////////////////////
	// Readback
	//////////////////////////////////////////////////

	// Unmapped addresses fall through as zero.
	always_comb begin
		rd_word = '0;
		if (cfg_addr_i == ADDR_CTRL) begin
			rd_word[N_CH-1:0] = mask_q;
			rd_word[CTRL_T1_MASK_BIT] = t1_mask_q;
		end
		for (int k = 0; k < N_CH; k++) begin
			if (cfg_addr_i == ADDR_CHAN_BASE + reg_addr_t'(k)) begin
				rd_word[CHAN_BLOCKS_LSB +: $bits(blocks_t)] = blocks_q[k];
				rd_word[CHAN_DELAY_LSB +: $bits(delay_t)] = delay_q[k];
			end
			// Counter words are full width.
			if (cfg_addr_i == ADDR_COUNT_BASE + reg_addr_t'(k)) begin
				rd_word = count_w[k];
			end
		end
	end

	// Address sampled on one edge, data shown after it.
	always_ff @(posedge fclk_i) begin
		if (rst_i) begin
			rdata_q <= '0;
		end else begin
			rdata_q <= rd_word;
		end
	end

	assign cfg_rdata_o = rdata_q;

endmodule

//--- trig_handler.sv
`timescale 1ns/10ps

module trig_handler #(
	parameter int N_CH = trig_types_pkg::NUM_CH
) (
	input  logic                    fclk_i,
	input  logic                    rst_i,
	trig_chan_if.sink               chans [N_CH],
	input  logic                    t1_mask_i,
	input  logic                    readout_ready_i,
	input  logic                    disable_i,
	input  logic                    disable_ce_i,
	output logic                    trig_o,
	output logic [N_CH-1:0]         trig_l4_o,
	output logic [N_CH-1:0]         trig_l4_new_o,
	output trig_types_pkg::delay_t  trig_delay_o
);
	import trig_types_pkg::*;

	// Aligned levels and new markers from the channels.
	logic [N_CH-1:0] act_w;
	logic [N_CH-1:0] new_w;
	delay_t dly_w [N_CH];
	// Disable latch.
	logic dis_q;
	// Global trigger is allowed this cycle.
	logic gate_ok;
	// Delay of the lowest channel with a new pulse.
	delay_t sel_delay;
	// Output registers.
	logic trig_q;
	logic [N_CH-1:0] l4_q;
	logic [N_CH-1:0] l4_new_q;
	delay_t delay_q;

	//////////////////////////////////////////////////
	// Channel gather
	//////////////////////////////////////////////////

	for (genvar g = 0; g < N_CH; g++) begin : g_sink
		assign act_w[g] = chans[g].active;
		assign new_w[g] = chans[g].new_pulse;
		assign dly_w[g] = chans[g].delay;
	end

	//////////////////////////////////////////////////
	// Gating
	//////////////////////////////////////////////////

	// Disable only moves when its strobe is up.
	always_ff @(posedge fclk_i) begin
		if (rst_i) begin
			dis_q <= 1'b0;
		end else if (disable_ce_i) begin
			dis_q <= disable_i;
		end
	end

	// Any one of the three holds back the global trigger.
	assign gate_ok = !t1_mask_i && readout_ready_i && !dis_q;

	// Walk down so the lowest channel wins.
	always_comb begin
		sel_delay = '0;
		for (int k = N_CH - 1; k >= 0; k--) begin
			if (new_w[k]) begin
				sel_delay = dly_w[k];
			end
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// Channel levels pass ungated; only the global pulse is masked.
	always_ff @(posedge fclk_i) begin
		if (rst_i) begin
			trig_q <= 1'b0;
			l4_q <= '0;
			l4_new_q <= '0;
			delay_q <= '0;
		end else begin
			trig_q <= (|new_w) && gate_ok;
			l4_q <= act_w;
			l4_new_q <= new_w;
			delay_q <= sel_delay;
		end
	end

	assign trig_o = trig_q;
	assign trig_l4_o = l4_q;
	assign trig_l4_new_o = l4_new_q;
	assign trig_delay_o = delay_q;

endmodule

//--- trig_regmap_pkg.sv
package trig_regmap_pkg;

	//////////////////////////////////////////////////
	// Register port types
	//////////////////////////////////////////////////

	// Register address, 16 words.
	typedef logic [3:0] reg_addr_t;

	// Register word.
	typedef logic [15:0] reg_data_t;

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	// Control word: channel masks in the low bits, T1 mask on top.
	localparam reg_addr_t ADDR_CTRL = 4'd0;

	// Channel k blocks and delay live at base plus k.
	localparam reg_addr_t ADDR_CHAN_BASE = 4'd1;

	// Channel k counter reads back at base plus k.
	localparam reg_addr_t ADDR_COUNT_BASE = 4'd8;

	//////////////////////////////////////////////////
	// Field positions
	//////////////////////////////////////////////////

	// Global trigger mask bit in the control word.
	localparam int CTRL_T1_MASK_BIT = 15;

	// Channel word fields.
	localparam int CHAN_BLOCKS_LSB = 0;
	localparam int CHAN_DELAY_LSB = 8;

endpackage

//--- trig_types_pkg.sv
package trig_types_pkg;

	//////////////////////////////////////////////////
	// Channel count
	//////////////////////////////////////////////////

	// Default number of level-4 sources.
	// Bit 0 is CPU, bit 1 is CAL, bit 2 is EXT.
	localparam int NUM_CH = 3;

	// Depth of the per-channel alignment shift line.
	localparam int DELAY_STAGES = 15;

	//////////////////////////////////////////////////
	// Datapath types
	//////////////////////////////////////////////////

	// Stretch length in cycles.
	// A value of 0 behaves as 1.
	typedef logic [7:0] blocks_t;

	// Alignment delay in cycles, 0 to 15.
	typedef logic [3:0] delay_t;

	// Accepted-trigger counter, wraps at the top.
	typedef logic [15:0] count_t;

	//////////////////////////////////////////////////
	// Channel state
	//////////////////////////////////////////////////

	// Idle waits for an unmasked flag.
	// Stretch holds the trigger for the programmed blocks.
	typedef enum logic {
		CH_IDLE    = 1'b0,
		CH_STRETCH = 1'b1
	} chan_state_e;

endpackage

//--- trigger_top.sv
`timescale 1ns/10ps

module trigger_top #(
	parameter int N_CH = trig_types_pkg::NUM_CH
) (
	input  logic                        fclk_i,
	input  logic                        rst_i,
	// Level-4 source flags, CPU, CAL and EXT from bit 0 up.
	input  logic [N_CH-1:0]             l4_flag_i,
	// Register port.
	input  logic                        cfg_we_i,
	input  trig_regmap_pkg::reg_addr_t  cfg_addr_i,
	input  trig_regmap_pkg::reg_data_t  cfg_wdata_i,
	output trig_regmap_pkg::reg_data_t  cfg_rdata_o,
	// Readout side.
	input  logic                        readout_ready_i,
	input  logic                        disable_i,
	input  logic                        disable_ce_i,
	output logic                        trig_o,
	output logic [N_CH-1:0]             trig_l4_o,
	output logic [N_CH-1:0]             trig_l4_new_o,
	output trig_types_pkg::delay_t      trig_delay_o
);

	// Global trigger mask from the control word.
	logic t1_mask;

	// One interface per source.
	trig_chan_if chan_if [N_CH] ();

	//////////////////////////////////////////////////
	// Register block
	//////////////////////////////////////////////////

	trig_ctrl_regs #(
		.N_CH(N_CH)
	) u_regs (
		.fclk_i      (fclk_i),
		.rst_i       (rst_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_rdata_o (cfg_rdata_o),
		.t1_mask_o   (t1_mask),
		.chans       (chan_if)
	);

	//////////////////////////////////////////////////
	// Source channels
	//////////////////////////////////////////////////

	// Each flag bit feeds its own channel.
	for (genvar g = 0; g < N_CH; g++) begin : g_l4
		l4_channel u_chan (
			.fclk_i (fclk_i),
			.rst_i  (rst_i),
			.flag_i (l4_flag_i[g]),
			.ch     (chan_if[g])
		);
	end

	//////////////////////////////////////////////////
	// Trigger handler
	//////////////////////////////////////////////////

	trig_handler #(
		.N_CH(N_CH)
	) u_handler (
		.fclk_i          (fclk_i),
		.rst_i           (rst_i),
		.chans           (chan_if),
		.t1_mask_i       (t1_mask),
		.readout_ready_i (readout_ready_i),
		.disable_i       (disable_i),
		.disable_ce_i    (disable_ce_i),
		.trig_o          (trig_o),
		.trig_l4_o       (trig_l4_o),
		.trig_l4_new_o   (trig_l4_new_o),
		.trig_delay_o    (trig_delay_o)
	);

endmodule
